//--- lc4_pkg.sv
package lc4_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_sel_t;
   typedef logic [2:0]  nzp_t;       // {n, z, p}

   typedef enum logic [1:0] {
      stall_none   = 2'd0,
      stall_branch = 2'd2,           // also what the pipe holds out of reset
      stall_load   = 2'd3
   } stall_t;

   typedef enum logic [3:0] {
      op_br      = 4'b0000,
      op_arith   = 4'b0001,
      op_logic   = 4'b0101,
      op_ldr     = 4'b0110,
      op_str     = 4'b0111,
      op_const   = 4'b1001,
      op_hiconst = 4'b1101
   } opcode_t;

   // decoder outputs that follow an instruction down the pipe
   typedef struct packed {
      logic     r1_re;
      logic     r2_re;
      logic     regfile_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      logic     is_branch;
      reg_sel_t wsel;
   } ctrl_t;

   typedef struct packed {
      word_t  pc;
      word_t  insn;
      stall_t stall;
   } fd_t;

   typedef struct packed {
      word_t    pc;
      word_t    insn;
      ctrl_t    ctrl;
      reg_sel_t r1_sel;
      reg_sel_t r2_sel;
      word_t    r1_data;
      word_t    r2_data;
      stall_t   stall;
   } dx_t;

   typedef struct packed {
      word_t  pc;
      word_t  insn;
      ctrl_t  ctrl;
      word_t  alu_result;
      word_t  store_data;
      stall_t stall;
   } xm_t;

   // store data is folded into dmem_data once the access is done
   typedef struct packed {
      word_t  pc;
      word_t  insn;
      ctrl_t  ctrl;
      word_t  alu_result;
      word_t  dmem_addr;
      word_t  dmem_data;
      stall_t stall;
   } mw_t;

   typedef struct packed {
      logic     we;
      reg_sel_t wsel;
      word_t    data;
   } wb_write_t;

   typedef struct packed {
      logic     we;
      logic     nzp_we;
      reg_sel_t wsel;
      word_t    value;
      logic     is_load;             // value is an address, the data is not back yet
   } fwd_t;

   typedef struct packed {
      logic  taken;
      word_t target;
   } redirect_t;

   typedef struct packed {
      word_t addr;
      logic  we;
      word_t wdata;
   } dmem_req_t;

   typedef struct packed {
      word_t    pc;
      word_t    insn;
      logic     regfile_we;
      reg_sel_t wsel;
      word_t    rd_data;
      logic     nzp_we;
      nzp_t     nzp_bits;
      logic     dmem_we;
      word_t    dmem_addr;
      word_t    dmem_data;
      stall_t   stall;
   } trace_t;

   localparam word_t reset_pc_default = 16'h8200;

   localparam fd_t fd_bubble = '{pc: '0, insn: '0, stall: stall_branch};
   localparam dx_t dx_bubble = '{pc: '0, insn: '0, ctrl: '0, r1_sel: '0, r2_sel: '0,
                                 r1_data: '0, r2_data: '0, stall: stall_branch};
   localparam xm_t xm_bubble = '{pc: '0, insn: '0, ctrl: '0, alu_result: '0,
                                 store_data: '0, stall: stall_branch};
   localparam mw_t mw_bubble = '{pc: '0, insn: '0, ctrl: '0, alu_result: '0,
                                 dmem_addr: '0, dmem_data: '0, stall: stall_branch};

   // condition code of a result written to the register file
   function automatic nzp_t nzp_of(input word_t value);
      if (value == '0) begin
         return 3'b010;
      end
      return value[15] ? 3'b100 : 3'b001;
   endfunction

endpackage

//--- lc4_pipe_reg.sv
`timescale 1ns/10ps

module lc4_pipe_reg #(
   parameter type      payload_t = logic,
   parameter payload_t bubble    = '0
) (
   input  logic     gwe,
   input  logic     i_reset,
   input  logic     i_hold,
   input  logic     i_flush,
   input  payload_t i_d,
   output payload_t o_q
);

   payload_t q;

   always_ff @(posedge gwe) begin
      if (i_reset || i_flush) begin
         q <= bubble;                // squashed slot retires with all enables low
      end else if (!i_hold) begin
         q <= i_d;
      end
   end

   assign o_q = q;

endmodule

//--- lc4_fetch.sv
`timescale 1ns/10ps

module lc4_fetch #(
   parameter lc4_pkg::word_t reset_pc = lc4_pkg::reset_pc_default
) (
   input  logic               gwe,
   input  logic               i_reset,
   input  logic               i_stall,
   input  lc4_pkg::redirect_t i_redirect,
   input  lc4_pkg::word_t     i_insn,
   output lc4_pkg::word_t     o_pc,
   output lc4_pkg::fd_t       o_fd
);
   import lc4_pkg::*;

   word_t pc;
   word_t next_pc;

   // a taken branch in execute wins over a load stall
   always_comb begin
      if (i_redirect.taken) begin
         next_pc = i_redirect.target;
      end else if (i_stall) begin
         next_pc = pc;               // refetch the same word
      end else begin
         next_pc = pc + 16'd1;       // predict not taken
      end
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc <= reset_pc;
      end else begin
         pc <= next_pc;
      end
   end

   assign o_pc = pc;
   assign o_fd = '{pc: pc, insn: i_insn, stall: stall_none};

endmodule

//--- lc4_regfile.sv
`timescale 1ns/10ps

module lc4_regfile (
   input  logic               gwe,
   input  logic               i_reset,
   input  lc4_pkg::reg_sel_t  i_rs,
   input  lc4_pkg::reg_sel_t  i_rt,
   input  lc4_pkg::wb_write_t i_write,
   output lc4_pkg::word_t     o_rs_data,
   output lc4_pkg::word_t     o_rt_data
);
   import lc4_pkg::*;

   word_t regs [0:7];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_write.we) begin
         regs[i_write.wsel] <= i_write.data;
      end
   end

   // writeback value shows up in the same cycle it is written
   assign o_rs_data = (i_write.we && i_write.wsel == i_rs) ? i_write.data : regs[i_rs];
   assign o_rt_data = (i_write.we && i_write.wsel == i_rt) ? i_write.data : regs[i_rt];

endmodule

//--- lc4_decode.sv
`timescale 1ns/10ps

module lc4_decode (
   input  logic               gwe,
   input  logic               i_reset,
   input  lc4_pkg::fd_t       i_fd,
   input  lc4_pkg::ctrl_t     i_ex_ctrl,
   input  lc4_pkg::wb_write_t i_write,
   output lc4_pkg::dx_t       o_dx,
   output logic               o_stall
);
   import lc4_pkg::*;

   opcode_t  op;
   ctrl_t    ctrl;
   reg_sel_t r1_sel;
   reg_sel_t r2_sel;
   word_t    rs_data;
   word_t    rt_data;
   logic     valid;

   assign op    = opcode_t'(i_fd.insn[15:12]);
   assign valid = (i_fd.stall == stall_none);   // bubbles decode with no enables

   always_comb begin
      ctrl      = '0;
      r1_sel    = i_fd.insn[8:6];
      r2_sel    = i_fd.insn[2:0];
      ctrl.wsel = i_fd.insn[11:9];
      case (op)
         op_br: begin
            ctrl.is_branch = 1'b1;
         end
         op_arith, op_logic: begin
            ctrl.r1_re      = 1'b1;
            // immediate forms and NOT use only one source
            ctrl.r2_re      = ~i_fd.insn[5] & ~(op == op_logic && i_fd.insn[5:3] == 3'b001);
            ctrl.regfile_we = 1'b1;
            ctrl.nzp_we     = 1'b1;
         end
         op_ldr: begin
            ctrl.r1_re      = 1'b1;
            ctrl.regfile_we = 1'b1;
            ctrl.nzp_we     = 1'b1;
            ctrl.is_load    = 1'b1;
         end
         op_str: begin
            r2_sel        = i_fd.insn[11:9];   // data to store
            ctrl.r1_re    = 1'b1;
            ctrl.r2_re    = 1'b1;
            ctrl.is_store = 1'b1;
         end
         op_const: begin
            ctrl.regfile_we = 1'b1;
            ctrl.nzp_we     = 1'b1;
         end
         op_hiconst: begin
            r1_sel          = i_fd.insn[11:9];   // low byte of rd is kept
            ctrl.r1_re      = 1'b1;
            ctrl.regfile_we = 1'b1;
            ctrl.nzp_we     = 1'b1;
         end
         default: begin
            ctrl.wsel = '0;          // retires as a nop
         end
      endcase
      if (!valid) begin
         ctrl = '0;
      end
   end

   lc4_regfile regfile0 (
      .gwe       (gwe),
      .i_reset   (i_reset),
      .i_rs      (r1_sel),
      .i_rt      (r2_sel),
      .i_write   (i_write),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

   // load in execute feeding this insn, or any BR since it needs the load's NZP
   assign o_stall = i_ex_ctrl.is_load &
                    ((ctrl.r1_re & (r1_sel == i_ex_ctrl.wsel)) |
                     (ctrl.r2_re & (r2_sel == i_ex_ctrl.wsel)) |
                     ctrl.is_branch);

   always_comb begin
      if (o_stall) begin
         o_dx       = dx_bubble;
         o_dx.stall = stall_load;
      end else begin
         o_dx = '{pc: i_fd.pc, insn: i_fd.insn, ctrl: ctrl, r1_sel: r1_sel, r2_sel: r2_sel,
                  r1_data: rs_data, r2_data: rt_data, stall: i_fd.stall};
      end
   end

endmodule

//--- lc4_execute.sv
`timescale 1ns/10ps

module lc4_execute (
   input  lc4_pkg::dx_t       i_dx,
   input  lc4_pkg::fwd_t      i_mem_fwd,
   input  lc4_pkg::fwd_t      i_wb_fwd,
   input  lc4_pkg::nzp_t      i_nzp_reg,
   output lc4_pkg::xm_t       o_xm,
   output lc4_pkg::ctrl_t     o_ex_ctrl,
   output lc4_pkg::redirect_t o_redirect
);
   import lc4_pkg::*;

   // youngest producer wins
   // a load in memory has no data yet and the load-use stall keeps consumers away
   function automatic word_t bypass(input reg_sel_t sel, input word_t rf_data,
                                    input fwd_t mem, input fwd_t wb);
      logic mem_hit;
      logic wb_hit;
      mem_hit = mem.we && !mem.is_load && (mem.wsel == sel);
      wb_hit  = wb.we && (wb.wsel == sel);
      return mem_hit ? mem.value : (wb_hit ? wb.value : rf_data);
   endfunction

   opcode_t    op;
   logic [2:0] subop;
   word_t      a;
   word_t      b;
   word_t      imm5;
   word_t      imm6;
   word_t      imm9;
   word_t      pc_plus_one;
   word_t      alu;
   nzp_t       nzp_cur;

   assign op    = opcode_t'(i_dx.insn[15:12]);
   assign subop = i_dx.insn[5:3];
   assign a     = bypass(i_dx.r1_sel, i_dx.r1_data, i_mem_fwd, i_wb_fwd);
   assign b     = bypass(i_dx.r2_sel, i_dx.r2_data, i_mem_fwd, i_wb_fwd);

   assign imm5 = {{11{i_dx.insn[4]}}, i_dx.insn[4:0]};
   assign imm6 = {{10{i_dx.insn[5]}}, i_dx.insn[5:0]};
   assign imm9 = {{7{i_dx.insn[8]}}, i_dx.insn[8:0]};
   assign pc_plus_one = i_dx.pc + 16'd1;

   always_comb begin
      alu = '0;
      case (op)
         op_arith: begin
            case (subop)
               3'b000:  alu = a + b;
               3'b001:  alu = a * b;
               3'b010:  alu = a - b;
               3'b011:  alu = '0;          // no divider in this core
               default: alu = a + imm5;    // bit 5 set, add immediate
            endcase
         end
         op_logic: begin
            case (subop)
               3'b000:  alu = a & b;
               3'b001:  alu = ~a;
               3'b010:  alu = a | b;
               3'b011:  alu = a ^ b;
               default: alu = a & imm5;
            endcase
         end
         op_ldr, op_str: alu = a + imm6;   // effective address
         op_const:       alu = imm9;
         op_hiconst:     alu = {i_dx.insn[7:0], a[7:0]};
         op_br:          alu = pc_plus_one + imm9;
         default:        alu = '0;
      endcase
   end

   // NZP of the youngest older writer, memory before writeback before the register
   always_comb begin
      if (i_mem_fwd.nzp_we) begin
         nzp_cur = nzp_of(i_mem_fwd.value);
      end else if (i_wb_fwd.nzp_we) begin
         nzp_cur = nzp_of(i_wb_fwd.value);
      end else begin
         nzp_cur = i_nzp_reg;
      end
   end

   assign o_redirect.taken  = i_dx.ctrl.is_branch & (|(i_dx.insn[11:9] & nzp_cur));
   assign o_redirect.target = alu;

   assign o_ex_ctrl = i_dx.ctrl;    // decode checks this for a pending load

   assign o_xm = '{pc: i_dx.pc, insn: i_dx.insn, ctrl: i_dx.ctrl, alu_result: alu,
                   store_data: b, stall: i_dx.stall};

endmodule

//--- lc4_mem_wb.sv
`timescale 1ns/10ps

module lc4_mem_wb (
   input  logic               gwe,
   input  logic               i_reset,
   input  lc4_pkg::xm_t       i_xm,
   input  lc4_pkg::mw_t       i_mw,
   input  lc4_pkg::word_t     i_dmem_data,
   output lc4_pkg::dmem_req_t o_dmem,
   output lc4_pkg::mw_t       o_mw,
   output lc4_pkg::fwd_t      o_mem_fwd,
   output lc4_pkg::fwd_t      o_wb_fwd,
   output lc4_pkg::wb_write_t o_write,
   output lc4_pkg::nzp_t      o_nzp,
   output lc4_pkg::trace_t    o_trace
);
   import lc4_pkg::*;

   word_t dmem_addr;
   word_t dmem_data;
   word_t rd_data;
   nzp_t  wb_nzp;
   nzp_t  nzp_q;

   // memory side
   assign dmem_addr = (i_xm.ctrl.is_load | i_xm.ctrl.is_store) ? i_xm.alu_result : '0;
   assign dmem_data = i_xm.ctrl.is_load  ? i_dmem_data :
                      i_xm.ctrl.is_store ? i_xm.store_data : '0;

   assign o_dmem = '{addr: dmem_addr, we: i_xm.ctrl.is_store, wdata: i_xm.store_data};

   assign o_mw = '{pc: i_xm.pc, insn: i_xm.insn, ctrl: i_xm.ctrl, alu_result: i_xm.alu_result,
                   dmem_addr: dmem_addr, dmem_data: dmem_data, stall: i_xm.stall};

   assign o_mem_fwd = '{we: i_xm.ctrl.regfile_we, nzp_we: i_xm.ctrl.nzp_we,
                        wsel: i_xm.ctrl.wsel, value: i_xm.alu_result,
                        is_load: i_xm.ctrl.is_load};

   // writeback side
   assign rd_data = i_mw.ctrl.is_load ? i_mw.dmem_data : i_mw.alu_result;
   assign wb_nzp  = nzp_of(rd_data);

   assign o_write  = '{we: i_mw.ctrl.regfile_we, wsel: i_mw.ctrl.wsel, data: rd_data};
   assign o_wb_fwd = '{we: i_mw.ctrl.regfile_we, nzp_we: i_mw.ctrl.nzp_we,
                       wsel: i_mw.ctrl.wsel, value: rd_data, is_load: i_mw.ctrl.is_load};

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         nzp_q <= '0;                // no condition set until the first write
      end else if (i_mw.ctrl.nzp_we) begin
         nzp_q <= wb_nzp;
      end
   end

   assign o_nzp = nzp_q;

   assign o_trace = '{pc: i_mw.pc, insn: i_mw.insn, regfile_we: i_mw.ctrl.regfile_we,
                      wsel: i_mw.ctrl.wsel, rd_data: rd_data, nzp_we: i_mw.ctrl.nzp_we,
                      nzp_bits: wb_nzp, dmem_we: i_mw.ctrl.is_store,
                      dmem_addr: i_mw.dmem_addr, dmem_data: i_mw.dmem_data,
                      stall: i_mw.stall};

endmodule

//--- lc4_core.sv
`timescale 1ns/10ps

module lc4_core #(
   parameter lc4_pkg::word_t reset_pc = lc4_pkg::reset_pc_default
) (
   input  logic               gwe,
   input  logic               i_reset,
   output lc4_pkg::word_t     o_cur_pc,
   input  lc4_pkg::word_t     i_cur_insn,
   output lc4_pkg::dmem_req_t o_dmem,
   input  lc4_pkg::word_t     i_dmem_data,
   output lc4_pkg::trace_t    o_trace
);
   import lc4_pkg::*;

   fd_t       fd_d;
   fd_t       fd_q;
   dx_t       dx_d;
   dx_t       dx_q;
   xm_t       xm_d;
   xm_t       xm_q;
   mw_t       mw_d;
   mw_t       mw_q;
   logic      stall;
   redirect_t redirect;
   ctrl_t     ex_ctrl;
   wb_write_t wb_write;
   fwd_t      mem_fwd;
   fwd_t      wb_fwd;
   nzp_t      nzp_reg;

   lc4_fetch #(.reset_pc(reset_pc)) fetch0 (
      .gwe(gwe), .i_reset(i_reset), .i_stall(stall), .i_redirect(redirect),
      .i_insn(i_cur_insn), .o_pc(o_cur_pc), .o_fd(fd_d));

   lc4_pipe_reg #(.payload_t(fd_t), .bubble(fd_bubble)) fd_reg (
      .gwe(gwe), .i_reset(i_reset), .i_hold(stall), .i_flush(redirect.taken),
      .i_d(fd_d), .o_q(fd_q));

   lc4_decode decode0 (
      .gwe(gwe), .i_reset(i_reset), .i_fd(fd_q), .i_ex_ctrl(ex_ctrl),
      .i_write(wb_write), .o_dx(dx_d), .o_stall(stall));

   lc4_pipe_reg #(.payload_t(dx_t), .bubble(dx_bubble)) dx_reg (
      .gwe(gwe), .i_reset(i_reset), .i_hold(1'b0), .i_flush(redirect.taken),
      .i_d(dx_d), .o_q(dx_q));

   lc4_execute execute0 (
      .i_dx(dx_q), .i_mem_fwd(mem_fwd), .i_wb_fwd(wb_fwd), .i_nzp_reg(nzp_reg),
      .o_xm(xm_d), .o_ex_ctrl(ex_ctrl), .o_redirect(redirect));

   lc4_pipe_reg #(.payload_t(xm_t), .bubble(xm_bubble)) xm_reg (
      .gwe(gwe), .i_reset(i_reset), .i_hold(1'b0), .i_flush(1'b0),
      .i_d(xm_d), .o_q(xm_q));

   lc4_mem_wb mem_wb0 (
      .gwe(gwe), .i_reset(i_reset), .i_xm(xm_q), .i_mw(mw_q), .i_dmem_data(i_dmem_data),
      .o_dmem(o_dmem), .o_mw(mw_d), .o_mem_fwd(mem_fwd), .o_wb_fwd(wb_fwd),
      .o_write(wb_write), .o_nzp(nzp_reg), .o_trace(o_trace));

   lc4_pipe_reg #(.payload_t(mw_t), .bubble(mw_bubble)) mw_reg (
      .gwe(gwe), .i_reset(i_reset), .i_hold(1'b0), .i_flush(1'b0),
      .i_d(mw_d), .o_q(mw_q));

endmodule

//--- lc4_core_props.sv
`timescale 1ns/10ps

module lc4_core_props (
   input logic               gwe,
   input logic               i_reset,
   input lc4_pkg::trace_t    i_trace,
   input lc4_pkg::dmem_req_t i_dmem
);
   import lc4_pkg::*;

   int fail_count;                   // failed assertions so far

   // single issue, so the pairing stall code never shows up
   a_no_pair_stall: assert property (@(posedge gwe) disable iff (i_reset)
      i_trace.stall != 2'd1)
      else begin
         $error("trace stall code 1 seen");
         fail_count++;
      end

   a_bubble_quiet: assert property (@(posedge gwe) disable iff (i_reset)
      (i_trace.stall != stall_none) |-> !(i_trace.regfile_we || i_trace.nzp_we || i_trace.dmem_we))
      else begin
         $error("bubble trace with an enable set");
         fail_count++;
      end

   // checked from the second reset edge on, once the stage registers are cleared
   a_no_store_in_reset: assert property (@(posedge gwe)
      i_reset |=> (!i_reset || !i_dmem.we))
      else begin
         $error("data memory write during reset");
         fail_count++;
      end

endmodule

//--- tb_lc4_model.svh
`ifndef TB_LC4_MODEL_SVH
`define TB_LC4_MODEL_SVH

// architectural state, one step per retired instruction
word_t    model_regs [0:7];
word_t    model_dmem [0:255];
word_t    model_pc;
nzp_t     model_nzp;
logic     model_prev_load;     // last retired insn was an LDR
reg_sel_t model_prev_rd;
logic     model_prev_taken;

function automatic nzp_t sign_code(input word_t value);
   return value[15] ? 3'b100 : ((value == 16'h0000) ? 3'b010 : 3'b001);
endfunction

function automatic word_t sext(input word_t field, input int width);
   word_t shifted;
   shifted = field << (16 - width);
   return word_t'($signed(shifted) >>> (16 - width));
endfunction

// register operands the ISA says an instruction reads
function automatic logic reads_reg(input word_t insn, input reg_sel_t r);
   logic [3:0] op;
   logic       uses_rt;
   op      = insn[15:12];
   uses_rt = !insn[5] && !(op == 4'b0101 && insn[5:3] == 3'b001);   // NOT has no rt
   case (op)
      4'b0001, 4'b0101: return (insn[8:6] == r) || (uses_rt && insn[2:0] == r);
      4'b0110:          return insn[8:6] == r;
      4'b0111:          return (insn[8:6] == r) || (insn[11:9] == r);
      4'b1101:          return insn[11:9] == r;
      default:          return 1'b0;
   endcase
endfunction

task automatic reset_model();
   for (int i = 0; i < 8; i++) begin
      model_regs[i] = 16'h0000;
   end
   model_pc         = 16'h8200;
   model_nzp        = 3'b000;
   model_prev_load  = 1'b0;
   model_prev_rd    = 3'd0;
   model_prev_taken = 1'b0;
endtask

// bubbles expected in the trace just before insn retires
task automatic next_gap(input word_t insn, output int len, output stall_t code);
   if (model_prev_taken) begin
      len  = 2;
      code = stall_branch;
   end else if (model_prev_load && (insn[15:12] == 4'b0000 || reads_reg(insn, model_prev_rd))) begin
      len  = 1;                // BR waits for the load's condition code too
      code = stall_load;
   end else begin
      len  = 0;
      code = stall_none;
   end
endtask

task automatic step_model(input word_t insn, output trace_t expected);
   logic [3:0] op;
   word_t      a;
   word_t      t;
   word_t      d;
   word_t      addr;
   word_t      result;
   logic       writes;
   logic       taken;
   op       = insn[15:12];
   a        = model_regs[insn[8:6]];
   t        = model_regs[insn[2:0]];
   d        = model_regs[insn[11:9]];
   result   = 16'h0000;
   writes   = 1'b0;
   taken    = 1'b0;
   expected = '0;
   expected.pc    = model_pc;
   expected.insn  = insn;
   expected.wsel  = insn[11:9];
   expected.stall = stall_none;
   case (op)
      4'b0000: taken = |(insn[11:9] & model_nzp);
      4'b0001: begin
         case (insn[5:3])
            3'b000:  result = a + t;
            3'b001:  result = a * t;
            3'b010:  result = a - t;
            default: result = a + sext(insn[4:0], 5);
         endcase
         writes = 1'b1;
      end
      4'b0101: begin
         case (insn[5:3])
            3'b000:  result = a & t;
            3'b001:  result = ~a;
            3'b010:  result = a | t;
            3'b011:  result = a ^ t;
            default: result = a & sext(insn[4:0], 5);
         endcase
         writes = 1'b1;
      end
      4'b0110: begin
         addr   = a + sext(insn[5:0], 6);
         result = model_dmem[addr[7:0]];
         writes = 1'b1;
         expected.dmem_addr = addr;
         expected.dmem_data = result;
      end
      4'b0111: begin
         addr = a + sext(insn[5:0], 6);
         model_dmem[addr[7:0]] = d;   // rt sits in the rd field for STR
         expected.dmem_we   = 1'b1;
         expected.dmem_addr = addr;
         expected.dmem_data = d;
      end
      4'b1001: begin
         result = sext(insn[8:0], 9);
         writes = 1'b1;
      end
      4'b1101: begin
         result = {insn[7:0], d[7:0]};
         writes = 1'b1;
      end
      default: ;
   endcase
   if (writes) begin
      model_regs[insn[11:9]] = result;
      model_nzp              = sign_code(result);
      expected.regfile_we    = 1'b1;
      expected.nzp_we        = 1'b1;
      expected.rd_data       = result;
      expected.nzp_bits      = model_nzp;
   end
   model_prev_load  = (op == 4'b0110);
   model_prev_rd    = insn[11:9];
   model_prev_taken = taken;
   model_pc = taken ? model_pc + 16'd1 + sext(insn[8:0], 9) : model_pc + 16'd1;
endtask

`endif

//--- tb_lc4_core.sv
`timescale 1ns/10ps

module tb_lc4_core;
   import lc4_pkg::*;

   localparam int    clk_period      = 40;
   localparam int    reset_cycles    = 8;
   localparam int    num_insns       = 200;
   localparam int    watchdog_cycles = num_insns * 3 + 50;
   localparam word_t start_pc        = 16'h8200;

   logic      gwe;
   logic      reset;
   word_t     cur_pc;
   word_t     cur_insn;
   dmem_req_t dmem_req;
   word_t     dmem_rdata;
   trace_t    trace_out;

   word_t imem [0:255];
   word_t dmem [0:255];

   `include "tb_lc4_model.svh"

   lc4_core #(.reset_pc(start_pc)) dut0 (
      .gwe(gwe), .i_reset(reset), .o_cur_pc(cur_pc), .i_cur_insn(cur_insn),
      .o_dmem(dmem_req), .i_dmem_data(dmem_rdata), .o_trace(trace_out));

   bind lc4_core lc4_core_props props0 (
      .gwe(gwe), .i_reset(i_reset), .i_trace(o_trace), .i_dmem(o_dmem));

   always #(clk_period / 2) gwe = ~gwe;

   // both memories decode the low 8 address bits only
   assign cur_insn   = imem[cur_pc[7:0]];
   assign dmem_rdata = dmem[dmem_req.addr[7:0]];

   always @(posedge gwe) begin
      if (dmem_req.we) begin
         dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
      end
   end

   task automatic report_error(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first mismatch");
   endtask

   task automatic check_word(input word_t actual, input word_t expected, input string what);
      if (actual !== expected) begin
         report_error($sformatf("%s is %h, expected %h", what, actual, expected));
      end
   endtask

   task automatic check_stall(input stall_t actual, input stall_t expected, input word_t pc);
      if (actual !== expected) begin
         report_error($sformatf("stall code %0d near pc %h, expected %0d", actual, pc, expected));
      end
   endtask

   function automatic logic has_enable(input trace_t t);
      return t.regfile_we | t.nzp_we | t.dmem_we;
   endfunction

   task automatic check_trace(input trace_t actual, input trace_t expected);
      string where;
      where = $sformatf("pc %h:", expected.pc);
      check_stall(actual.stall, expected.stall, expected.pc);
      check_word(actual.pc, expected.pc, "retired pc");
      check_word(actual.insn, expected.insn, {where, " insn"});
      if ({actual.regfile_we, actual.nzp_we, actual.dmem_we} !==
          {expected.regfile_we, expected.nzp_we, expected.dmem_we}) begin
         report_error($sformatf("%s enables %b, expected %b", where,
                      {actual.regfile_we, actual.nzp_we, actual.dmem_we},
                      {expected.regfile_we, expected.nzp_we, expected.dmem_we}));
      end
      if (expected.regfile_we && actual.wsel !== expected.wsel) begin
         report_error($sformatf("%s wsel r%0d, expected r%0d", where, actual.wsel, expected.wsel));
      end
      if (expected.regfile_we) begin
         check_word(actual.rd_data, expected.rd_data, {where, " rd data"});
      end
      if (expected.nzp_we && actual.nzp_bits !== expected.nzp_bits) begin
         report_error($sformatf("%s nzp %b, expected %b", where, actual.nzp_bits,
                      expected.nzp_bits));
      end
      check_word(actual.dmem_addr, expected.dmem_addr, {where, " dmem addr"});
      check_word(actual.dmem_data, expected.dmem_data, {where, " dmem data"});
   endtask

   task automatic check_bubble(input trace_t actual, input stall_t expected, input word_t pc);
      check_stall(actual.stall, expected, pc);
      if (has_enable(actual)) begin
         report_error($sformatf("bubble near pc %h has an enable set", pc));
      end
   endtask

   // low registers more often so that back-to-back dependences are common
   function automatic reg_sel_t pick_reg();
      return (($urandom & 3) != 0) ? reg_sel_t'($urandom_range(0, 3)) :
                                     reg_sel_t'($urandom_range(0, 7));
   endfunction

   task automatic build_program();
      int         i;
      int         kind;
      reg_sel_t   rd;
      reg_sel_t   rs;
      reg_sel_t   rt;
      logic [5:0] off;
      i = 0;
      while (i < num_insns) begin
         kind = $urandom_range(0, 16);
         rd   = pick_reg();
         rs   = pick_reg();
         rt   = pick_reg();
         off  = 6'($urandom);
         case (kind)
            0, 1, 2:    imem[i] = {4'b0001, rd, rs, 1'b0, kind[1:0], rt};   // add mul sub
            3:          imem[i] = {4'b0001, rd, rs, 1'b1, 5'($urandom)};
            4, 5, 6, 7: imem[i] = {4'b0101, rd, rs, 1'b0, kind[1:0], rt};   // and not or xor
            8:          imem[i] = {4'b0101, rd, rs, 1'b1, 5'($urandom)};
            9:          imem[i] = {4'b1001, rd, 9'($urandom)};
            10:         imem[i] = {4'b1101, rd, 1'b1, 8'($urandom)};
            11:         imem[i] = {4'b0110, rd, rs, off};
            12:         imem[i] = {4'b0111, rt, rs, off};
            13, 14:     imem[i] = {4'b0000, 3'($urandom), 9'($urandom_range(0, 4))};
            default: begin
               if (i + 1 < num_insns) begin
                  imem[i] = {4'b0111, rt, rs, off};   // store then load the same word
                  i++;
                  imem[i] = {4'b0110, rd, rs, off};
               end else begin
                  imem[i] = {4'b1001, rd, 9'($urandom)};
               end
            end
         endcase
         i++;
      end
      for (int j = num_insns; j < 256; j++) begin
         imem[j] = {4'b0000, 3'b000, 1'b0, 8'(j)};   // never-taken BR
      end
      for (int j = 0; j < 256; j++) begin
         dmem[j]       = (j < 64) ? 16'($urandom) : {8'(~j), 8'(j)};
         model_dmem[j] = dmem[j];
      end
   endtask

   initial begin
      trace_t expected;
      int     gap_len;
      stall_t gap_code;
      logic   started;
      logic   done;
      gwe         = 1'b0;
      reset       = 1'b1;
      void'($urandom(32'hf941));
      build_program();
      reset_model();
      repeat (reset_cycles) @(posedge gwe);
      reset <= 1'b0;
      started  = 1'b0;
      done     = 1'b0;
      gap_len  = 0;
      gap_code = stall_none;
      while (!done) begin
         @(negedge gwe);
         if (dut0.props0.fail_count != 0) begin
            report_error("an assertion on the trace or data memory port failed");
         end
         if (!started && trace_out.stall != stall_none) begin
            if (has_enable(trace_out)) begin
               report_error("trace before the first retirement has an enable set");
            end
         end else if (gap_len > 0) begin
            check_bubble(trace_out, gap_code, model_pc);
            gap_len--;
         end else begin
            if (!started) begin
               check_word(trace_out.pc, start_pc, "first retired pc");
               started = 1'b1;
            end
            step_model(imem[model_pc[7:0]], expected);
            check_trace(trace_out, expected);
            // the store went out one edge before it retires
            if (expected.dmem_we) begin
               check_word(dmem[expected.dmem_addr[7:0]], expected.dmem_data, "stored word");
            end
            done = (model_pc[7:0] >= num_insns);
            if (!done) begin
               next_gap(imem[model_pc[7:0]], gap_len, gap_code);
            end
         end
      end
      $display("TEST OK");
      $finish;
   end

   // every instruction retires within three cycles, the rest covers reset and fill
   initial begin
      #(watchdog_cycles * clk_period);
      $display("timeout: the program did not finish within %0d cycles", watchdog_cycles);
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- src.f
+incdir+.
lc4_pkg.sv
lc4_pipe_reg.sv
lc4_fetch.sv
lc4_regfile.sv
lc4_decode.sv
lc4_execute.sv
lc4_mem_wb.sv
lc4_core.sv
lc4_core_props.sv
tb_lc4_core.sv

//--- Bender.yml
package:
  name: lc4_core

sources:
  - files:
      - lc4_pkg.sv
      - lc4_pipe_reg.sv
      - lc4_fetch.sv
      - lc4_regfile.sv
      - lc4_decode.sv
      - lc4_execute.sv
      - lc4_mem_wb.sv
      - lc4_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - lc4_core_props.sv
      - tb_lc4_core.sv
